/* logic/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import id_pkg::*; (
    input  br_kind_t br_kind,
    input  data_t    rj_value,
    input  data_t    rkd_value,
    input  data_t    pc,
    input  data_t    br_offs,
    input  logic     accept,
    output logic     br_taken,
    output data_t    br_target
);

    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    data_t base;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    // jirl, b and bl are always taken.
    assign cond = (br_kind[BR_BEQ] && eq) || (br_kind[BR_BNE] && !eq)
                  || (br_kind[BR_BLT] && lt) || (br_kind[BR_BGE] && !lt)
                  || (br_kind[BR_BLTU] && ltu) || (br_kind[BR_BGEU] && !ltu)
                  || br_kind[BR_JIRL] || br_kind[BR_DIRECT];

    assign base = br_kind[BR_JIRL] ? rj_value : pc;

    // the fetch stage only sees a redirect for an instruction actually taken in.
    assign br_taken  = accept && cond;
    assign br_target = accept ? base + br_offs : '0;

endmodule

/* logic/hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl import id_pkg::*; (
    input  logic      rst,
    input  logic      in_valid,
    input  logic      out_ready,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      out_valid,
    input  logic      gr_we_out,
    input  logic      res_from_mem_out,
    input  reg_addr_t dest_out,
    input  logic      mem_valid,
    input  logic      mem_gr_we,
    input  logic      mem_res_from_mem,
    input  reg_addr_t mem_dest,
    output logic      in_ready,
    output logic      accept
);

    logic ex_load;
    logic mem_load;
    logic load_use;
    logic ready_go;

    assign ex_load  = out_valid && gr_we_out && res_from_mem_out;
    assign mem_load = mem_valid && mem_gr_we && mem_res_from_mem;

    // the stall lasts until the load reaches writeback, where it can be bypassed.
    assign load_use = in_valid
                      && ((ex_load && (raddr1 == dest_out || raddr2 == dest_out))
                      || (mem_load && (raddr1 == mem_dest || raddr2 == mem_dest)));

    assign ready_go = !in_valid || !load_use;
    assign in_ready = !rst && (!in_valid || (ready_go && out_ready));
    assign accept   = in_valid && in_ready;

endmodule

/* logic/id_pkg.sv */
package id_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [11:0]     alu_op_t;
    typedef logic [7:0]      mem_op_t;
    typedef logic [7:0]      br_kind_t;

    // one-hot positions in alu_op_t.
    localparam int ALU_ADD = 0, ALU_SUB = 1, ALU_SLT = 2,  ALU_SLTU = 3,
                   ALU_AND = 4, ALU_NOR = 5, ALU_OR  = 6,  ALU_XOR  = 7,
                   ALU_SLL = 8, ALU_SRL = 9, ALU_SRA = 10, ALU_LUI  = 11;

    // one-hot positions in mem_op_t, the five loads first and then the three stores.
    localparam int MEM_LD_B  = 0, MEM_LD_H = 1, MEM_LD_W = 2, MEM_LD_BU = 3,
                   MEM_LD_HU = 4, MEM_ST_B = 5, MEM_ST_H = 6, MEM_ST_W  = 7;

    // one-hot positions in br_kind_t.
    localparam int BR_BEQ  = 0, BR_BNE  = 1, BR_BLT  = 2, BR_BGE    = 3,
                   BR_BLTU = 4, BR_BGEU = 5, BR_JIRL = 6, BR_DIRECT = 7; // direct is b and bl.

    // major opcodes in inst[31:26].
    localparam logic [5:0] OP_ALU       = 6'h00,
                           OP_LU12I     = 6'h05,
                           OP_PCADDU12I = 6'h07,
                           OP_MEM       = 6'h0a;
    localparam logic [5:0] OP_JIRL = 6'h13, OP_B    = 6'h14, OP_BL  = 6'h15,
                           OP_BEQ  = 6'h16, OP_BNE  = 6'h17, OP_BLT = 6'h18,
                           OP_BGE  = 6'h19, OP_BLTU = 6'h1a, OP_BGEU = 6'h1b;

    // inst[25:22] under OP_ALU.
    localparam logic [3:0] F22_REG3  = 4'h0, F22_SHIFT = 4'h1, F22_SLTI = 4'h8,
                           F22_SLTUI = 4'h9, F22_ADDI  = 4'ha, F22_ANDI = 4'hd,
                           F22_ORI   = 4'he, F22_XORI  = 4'hf;

    // inst[21:20] separates three-register ops from shifts by immediate.
    localparam logic [1:0] F20_REG3 = 2'h1, F20_SHIFT = 2'h0;

    // inst[19:15] of the three-register ops.
    localparam logic [4:0] F15_ADD = 5'h00, F15_SUB = 5'h02, F15_SLT = 5'h04,
                           F15_SLTU = 5'h05, F15_NOR = 5'h08, F15_AND = 5'h09,
                           F15_OR  = 5'h0a, F15_XOR = 5'h0b, F15_SLL = 5'h0e,
                           F15_SRL = 5'h0f, F15_SRA = 5'h10;

    // inst[19:15] of the shifts by immediate.
    localparam logic [4:0] F15_SLLI = 5'h01, F15_SRLI = 5'h09, F15_SRAI = 5'h11;

    // inst[25:22] under OP_MEM.
    localparam logic [3:0] F22_LD_B  = 4'h0, F22_LD_H  = 4'h1, F22_LD_W = 4'h2,
                           F22_ST_B  = 4'h4, F22_ST_H  = 4'h5, F22_ST_W = 4'h6,
                           F22_LD_BU = 4'h8, F22_LD_HU = 4'h9;

    localparam reg_addr_t LINK_REG         = 5'd1;
    localparam data_t     DEFAULT_RESET_PC = 32'h1c000000;

endpackage

/* logic/id_stage.sv */
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
    parameter data_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  data_t     inst,
    input  data_t     pc,
    input  logic      out_ready,
    output logic      out_valid,
    input  data_t     ex_result,
    input  logic      mem_valid,
    input  logic      mem_gr_we,
    input  logic      mem_res_from_mem,
    input  reg_addr_t mem_dest,
    input  data_t     mem_result,
    input  logic      wb_valid,
    input  logic      wb_gr_we,
    input  logic      wb_res_from_mem,
    input  reg_addr_t wb_dest,
    input  data_t     wb_load_data,
    input  data_t     wb_result,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  data_t     rf_rdata1,
    input  data_t     rf_rdata2,
    output logic      br_taken,
    output data_t     br_target,
    output mem_op_t   load_op_out,
    output alu_op_t   alu_op_out,
    output logic      src1_is_pc_out,
    output logic      src2_is_imm_out,
    output logic      res_from_mem_out,
    output logic      gr_we_out,
    output logic      mem_we_out,
    output reg_addr_t dest_out,
    output data_t     imm_out,
    output data_t     pc_out,
    output data_t     rj_value_out,
    output data_t     rkd_value_out
);

    alu_op_t   alu_op;
    mem_op_t   mem_op;
    logic      src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we;
    reg_addr_t dest;
    data_t     imm;
    br_kind_t  br_kind;
    data_t     br_offs;
    data_t     rj_value;
    data_t     rkd_value;
    logic      accept;

    // ports not listed connect by name.
    inst_decoder u_decoder (.raddr1(rf_raddr1), .raddr2(rf_raddr2), .*);

    // the instruction held in the output register is the one now in execute.
    operand_bypass u_bypass_rj (
        .raddr(rf_raddr1), .ex_valid(out_valid), .ex_gr_we(gr_we_out),
        .ex_res_from_mem(res_from_mem_out), .ex_dest(dest_out),
        .rf_rdata(rf_rdata1), .value(rj_value), .*
    );

    operand_bypass u_bypass_rkd (
        .raddr(rf_raddr2), .ex_valid(out_valid), .ex_gr_we(gr_we_out),
        .ex_res_from_mem(res_from_mem_out), .ex_dest(dest_out),
        .rf_rdata(rf_rdata2), .value(rkd_value), .*
    );

    branch_unit u_branch (.*);

    hazard_ctrl u_hazard (.raddr1(rf_raddr1), .raddr2(rf_raddr2), .*);

    id_stage_reg #(.RESET_PC(RESET_PC)) u_stage_reg (.*);

endmodule

/* logic/id_stage_reg.sv */
`timescale 1ns/1ps

module id_stage_reg import id_pkg::*; #(
    parameter data_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      accept,
    input  logic      out_ready,
    input  alu_op_t   alu_op,
    input  mem_op_t   mem_op,
    input  logic      src1_is_pc,
    input  logic      src2_is_imm,
    input  logic      res_from_mem,
    input  logic      gr_we,
    input  logic      mem_we,
    input  reg_addr_t dest,
    input  data_t     imm,
    input  data_t     pc,
    input  data_t     rj_value,
    input  data_t     rkd_value,
    output logic      out_valid,
    output alu_op_t   alu_op_out,
    output mem_op_t   load_op_out,
    output logic      src1_is_pc_out,
    output logic      src2_is_imm_out,
    output logic      res_from_mem_out,
    output logic      gr_we_out,
    output logic      mem_we_out,
    output reg_addr_t dest_out,
    output data_t     imm_out,
    output data_t     pc_out,
    output data_t     rj_value_out,
    output data_t     rkd_value_out
);

    // a stalled decode leaves a bubble behind once execute takes the current word.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= accept;
        end
    end

    // accept already implies out_ready, so everything holds under back-pressure.
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op_out       <= '0;
            load_op_out      <= '0;
            src1_is_pc_out   <= 1'b0;
            src2_is_imm_out  <= 1'b0;
            res_from_mem_out <= 1'b0;
            gr_we_out        <= 1'b0;
            mem_we_out       <= 1'b0;
            dest_out         <= '0;
            imm_out          <= '0;
            pc_out           <= RESET_PC;
            rj_value_out     <= '0;
            rkd_value_out    <= '0;
        end else if (accept) begin
            alu_op_out       <= alu_op;
            load_op_out      <= mem_op;
            src1_is_pc_out   <= src1_is_pc;
            src2_is_imm_out  <= src2_is_imm;
            res_from_mem_out <= res_from_mem;
            gr_we_out        <= gr_we;
            mem_we_out       <= mem_we;
            dest_out         <= dest;
            imm_out          <= imm;
            pc_out           <= pc;
            rj_value_out     <= rj_value;
            rkd_value_out    <= rkd_value;
        end
    end

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
    input  data_t     inst,
    output alu_op_t   alu_op,
    output mem_op_t   mem_op,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      res_from_mem,
    output logic      gr_we,
    output logic      mem_we,
    output reg_addr_t dest,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output data_t     imm,
    output br_kind_t  br_kind,
    output data_t     br_offs
);

    logic [5:0] op;
    logic [3:0] f22;
    logic [1:0] f20;
    logic [4:0] f15;
    reg_addr_t  rd;
    reg_addr_t  rj;
    reg_addr_t  rk;
    logic       is_alu, is_reg3, is_shift, is_mem, is_load, is_store, is_cond_br;
    logic       inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and;
    logic       inst_or, inst_xor, inst_sll, inst_srl, inst_sra;
    logic       inst_slli, inst_srli, inst_srai;
    logic       inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
    logic       inst_lu12i, inst_pcaddu12i, inst_jirl, inst_bl;

    assign op  = inst[31:26];
    assign f22 = inst[25:22];
    assign f20 = inst[21:20];
    assign f15 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];

    assign is_alu   = (op == OP_ALU);
    assign is_reg3  = is_alu && f22 == F22_REG3 && f20 == F20_REG3;
    assign is_shift = is_alu && f22 == F22_SHIFT && f20 == F20_SHIFT;
    assign is_mem   = (op == OP_MEM);

    assign inst_add  = is_reg3 && f15 == F15_ADD;
    assign inst_sub  = is_reg3 && f15 == F15_SUB;
    assign inst_slt  = is_reg3 && f15 == F15_SLT;
    assign inst_sltu = is_reg3 && f15 == F15_SLTU;
    assign inst_nor  = is_reg3 && f15 == F15_NOR;
    assign inst_and  = is_reg3 && f15 == F15_AND;
    assign inst_or   = is_reg3 && f15 == F15_OR;
    assign inst_xor  = is_reg3 && f15 == F15_XOR;
    assign inst_sll  = is_reg3 && f15 == F15_SLL;
    assign inst_srl  = is_reg3 && f15 == F15_SRL;
    assign inst_sra  = is_reg3 && f15 == F15_SRA;
    assign inst_slli = is_shift && f15 == F15_SLLI;
    assign inst_srli = is_shift && f15 == F15_SRLI;
    assign inst_srai = is_shift && f15 == F15_SRAI;

    assign inst_slti  = is_alu && f22 == F22_SLTI;
    assign inst_sltui = is_alu && f22 == F22_SLTUI;
    assign inst_addi  = is_alu && f22 == F22_ADDI;
    assign inst_andi  = is_alu && f22 == F22_ANDI;
    assign inst_ori   = is_alu && f22 == F22_ORI;
    assign inst_xori  = is_alu && f22 == F22_XORI;

    assign inst_lu12i     = op == OP_LU12I && !inst[25];  // bit 25 is part of the opcode here.
    assign inst_pcaddu12i = op == OP_PCADDU12I && !inst[25];
    assign inst_jirl      = (op == OP_JIRL);
    assign inst_bl        = (op == OP_BL);

    assign mem_op[MEM_LD_B]  = is_mem && f22 == F22_LD_B;
    assign mem_op[MEM_LD_H]  = is_mem && f22 == F22_LD_H;
    assign mem_op[MEM_LD_W]  = is_mem && f22 == F22_LD_W;
    assign mem_op[MEM_LD_BU] = is_mem && f22 == F22_LD_BU;
    assign mem_op[MEM_LD_HU] = is_mem && f22 == F22_LD_HU;
    assign mem_op[MEM_ST_B]  = is_mem && f22 == F22_ST_B;
    assign mem_op[MEM_ST_H]  = is_mem && f22 == F22_ST_H;
    assign mem_op[MEM_ST_W]  = is_mem && f22 == F22_ST_W;
    assign is_load  = |mem_op[MEM_LD_HU:MEM_LD_B];
    assign is_store = |mem_op[MEM_ST_W:MEM_ST_B];

    assign br_kind[BR_BEQ]    = (op == OP_BEQ);
    assign br_kind[BR_BNE]    = (op == OP_BNE);
    assign br_kind[BR_BLT]    = (op == OP_BLT);
    assign br_kind[BR_BGE]    = (op == OP_BGE);
    assign br_kind[BR_BLTU]   = (op == OP_BLTU);
    assign br_kind[BR_BGEU]   = (op == OP_BGEU);
    assign br_kind[BR_JIRL]   = inst_jirl;
    assign br_kind[BR_DIRECT] = (op == OP_B) || inst_bl;
    assign is_cond_br = |br_kind[BR_BGEU:BR_BEQ];

    // the adder also forms load/store addresses and the link value pc + 4.
    assign alu_op[ALU_ADD]  = inst_add || inst_addi || is_load || is_store
                              || inst_jirl || inst_bl || inst_pcaddu12i;
    assign alu_op[ALU_SUB]  = inst_sub;
    assign alu_op[ALU_SLT]  = inst_slt || inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu || inst_sltui;
    assign alu_op[ALU_AND]  = inst_and || inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or || inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor || inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll || inst_slli;
    assign alu_op[ALU_SRL]  = inst_srl || inst_srli;
    assign alu_op[ALU_SRA]  = inst_sra || inst_srai;
    assign alu_op[ALU_LUI]  = inst_lu12i;

    assign src1_is_pc   = inst_jirl || inst_bl || inst_pcaddu12i;
    assign src2_is_imm  = inst_slli || inst_srli || inst_srai || inst_slti || inst_sltui
                          || inst_addi || inst_andi || inst_ori || inst_xori || is_load
                          || is_store || inst_lu12i || inst_pcaddu12i || inst_jirl || inst_bl;
    assign res_from_mem = is_load;
    assign mem_we       = is_store;
    assign gr_we        = (|alu_op) && !is_store;  // stores use the ALU only for the address.

    assign dest   = inst_bl ? LINK_REG : rd;
    assign raddr1 = rj;
    assign raddr2 = (is_store || is_cond_br) ? rd : rk;  // stores and branches read rd.

    assign imm = (inst_jirl || inst_bl)         ? 32'd4 :
                 (inst_lu12i || inst_pcaddu12i) ? {inst[24:5], 12'b0} :
                                                  {{20{inst[21]}}, inst[21:10]};

    assign br_offs = br_kind[BR_DIRECT] ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                        : {{14{inst[25]}}, inst[25:10], 2'b0};

endmodule

/* logic/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import id_pkg::*; (
    input  reg_addr_t raddr,
    input  logic      ex_valid,
    input  logic      ex_gr_we,
    input  logic      ex_res_from_mem,
    input  reg_addr_t ex_dest,
    input  data_t     ex_result,
    input  logic      mem_valid,
    input  logic      mem_gr_we,
    input  logic      mem_res_from_mem,
    input  reg_addr_t mem_dest,
    input  data_t     mem_result,
    input  logic      wb_valid,
    input  logic      wb_gr_we,
    input  logic      wb_res_from_mem,
    input  reg_addr_t wb_dest,
    input  data_t     wb_load_data,
    input  data_t     wb_result,
    input  data_t     rf_rdata,
    output data_t     value
);

    logic nonzero;
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    assign nonzero = (raddr != '0);  // r0 reads as zero and is never forwarded.

    // a load has no data before writeback, so execute and memory cannot supply it.
    assign ex_hit  = ex_valid && ex_gr_we && !ex_res_from_mem && ex_dest == raddr && nonzero;
    assign mem_hit = mem_valid && mem_gr_we && !mem_res_from_mem && mem_dest == raddr
                     && nonzero;
    assign wb_hit  = wb_valid && wb_gr_we && wb_dest == raddr && nonzero;

    // the youngest writer wins.
    always_comb begin
        if (ex_hit) begin
            value = ex_result;
        end else if (mem_hit) begin
            value = mem_result;
        end else if (wb_hit) begin
            value = wb_res_from_mem ? wb_load_data : wb_result;
        end else begin
            value = rf_rdata;
        end
    end

endmodule

/* project.f */
+incdir+testbench
logic/id_pkg.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/hazard_ctrl.sv
logic/id_stage_reg.sv
logic/id_stage.sv
testbench/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_id_stage -o sim_tb_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi

/* testbench/tb_id_vectors.svh */
// operand source codes used by the table to name where an operand must come from.
localparam logic [2:0] SRC_RF   = 3'd0;
localparam logic [2:0] SRC_EX   = 3'd1;
localparam logic [2:0] SRC_MEM  = 3'd2;
localparam logic [2:0] SRC_WB   = 3'd3;
localparam logic [2:0] SRC_WBLD = 3'd4;

// first line of a row: hs {in_valid, out_ready}, inst, pc, mem {valid, load}, mem_dest,
// wb {valid, load}, wb_dest, pre {in_ready, br_taken, check target}, br_target, rf_raddr2.
// second line: post {hold, out_valid}, alu_op, load_op,
// {src1_is_pc, res_from_mem, gr_we, mem_we, src2_is_imm}, dest, imm, rj source, rkd source.
typedef struct packed {
    logic [1:0] hs;
    data_t      inst;
    data_t      pc;
    logic [1:0] mem_fwd;
    reg_addr_t  mem_dest;
    logic [1:0] wb_fwd;
    reg_addr_t  wb_dest;
    logic [2:0] pre;
    data_t      br_target;
    reg_addr_t  raddr2;
    logic [1:0] post;       // hold means the registered outputs must not change.
    alu_op_t    alu;
    mem_op_t    mem;
    logic [4:0] flags;
    reg_addr_t  dest;
    data_t      imm;
    logic [2:0] rj_src;
    logic [2:0] rkd_src;
} vec_t;

localparam int NUM_VECS = 25;

localparam vec_t VECS [NUM_VECS] = '{
    '{2'b11, 32'h00100C44, 32'h1C000000, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd3,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd4, 32'h00000403, SRC_RF, SRC_RF},
    '{2'b11, 32'h02BFF045, 32'h1C000004, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd28,
      2'b01, 12'h001, 8'h00, 5'b00101, 5'd5, 32'hFFFFFFFC, SRC_RF, SRC_RF},
    '{2'b11, 32'h00408C46, 32'h1C000008, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd3,
      2'b01, 12'h100, 8'h00, 5'b00101, 5'd6, 32'h00000023, SRC_RF, SRC_RF},
    '{2'b11, 32'h142468A7, 32'h1C00000C, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd26,
      2'b01, 12'h800, 8'h00, 5'b00101, 5'd7, 32'h12345000, SRC_RF, SRC_RF},
    '{2'b11, 32'h1C000028, 32'h1C000010, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd0,
      2'b01, 12'h001, 8'h00, 5'b10101, 5'd8, 32'h00001000, SRC_RF, SRC_RF},
    '{2'b11, 32'h2980304A, 32'h1C000014, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd10,
      2'b01, 12'h001, 8'h80, 5'b00011, 5'd10, 32'h0000000C, SRC_RF, SRC_RF},
    '{2'b11, 32'h28802049, 32'h1C000018, 2'b00, 5'd0, 2'b00, 5'd0, 3'b100, 32'h0, 5'd8,
      2'b01, 12'h001, 8'h04, 5'b01101, 5'd9, 32'h00000008, SRC_RF, SRC_RF},
    '{2'b11, 32'h00100D2B, 32'h1C00001C, 2'b00, 5'd0, 2'b00, 5'd0, 3'b001, 32'h0, 5'd3,
      2'b10, 12'h000, 8'h00, 5'b00000, 5'd0, 32'h0, SRC_RF, SRC_RF},
    '{2'b11, 32'h00100D2B, 32'h1C00001C, 2'b11, 5'd9, 2'b00, 5'd0, 3'b001, 32'h0, 5'd3,
      2'b10, 12'h000, 8'h00, 5'b00000, 5'd0, 32'h0, SRC_RF, SRC_RF},
    '{2'b11, 32'h00100D2B, 32'h1C00001C, 2'b00, 5'd0, 2'b11, 5'd9, 3'b100, 32'h0, 5'd3,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd11, 32'h00000403, SRC_WBLD, SRC_RF},
    '{2'b11, 32'h0010356C, 32'h1C000020, 2'b10, 5'd11, 2'b10, 5'd11, 3'b100, 32'h0, 5'd13,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd12, 32'h0000040D, SRC_EX, SRC_RF},
    '{2'b11, 32'h001001AE, 32'h1C000024, 2'b10, 5'd13, 2'b10, 5'd13, 3'b100, 32'h0, 5'd0,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd14, 32'h00000400, SRC_MEM, SRC_RF},
    '{2'b11, 32'h0010400F, 32'h1C000028, 2'b10, 5'd0, 2'b10, 5'd0, 3'b100, 32'h0, 5'd16,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd15, 32'h00000410, SRC_RF, SRC_RF},
    '{2'b11, 32'h00104E51, 32'h1C00002C, 2'b00, 5'd0, 2'b10, 5'd18, 3'b100, 32'h0, 5'd19,
      2'b01, 12'h001, 8'h00, 5'b00100, 5'd17, 32'h00000413, SRC_WB, SRC_RF},
    '{2'b11, 32'h58001295, 32'h1C000100, 2'b10, 5'd20, 2'b10, 5'd21, 3'b101, 32'h1C000110,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h5C001295, 32'h1C000104, 2'b10, 5'd20, 2'b10, 5'd21, 3'b111, 32'h1C000114,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h60001295, 32'h1C000108, 2'b10, 5'd20, 2'b10, 5'd21, 3'b101, 32'h1C000118,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h64001295, 32'h1C00010C, 2'b10, 5'd20, 2'b10, 5'd21, 3'b111, 32'h1C00011C,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h68001295, 32'h1C000110, 2'b10, 5'd20, 2'b10, 5'd21, 3'b111, 32'h1C000120,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h6C001295, 32'h1C000114, 2'b10, 5'd20, 2'b10, 5'd21, 3'b101, 32'h1C000124,
      5'd21, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd21, 32'h00000004, SRC_MEM, SRC_WB},
    '{2'b11, 32'h4C002281, 32'h1C000118, 2'b10, 5'd20, 2'b10, 5'd21, 3'b111, 32'h3E3E3E5E,
      5'd8, 2'b01, 12'h001, 8'h00, 5'b10101, 5'd1, 32'h00000004, SRC_MEM, SRC_RF},
    '{2'b11, 32'h54010000, 32'h1C00011C, 2'b00, 5'd0, 2'b00, 5'd0, 3'b111, 32'h1C00021C,
      5'd0, 2'b01, 12'h001, 8'h00, 5'b10101, 5'd1, 32'h00000004, SRC_RF, SRC_RF},
    '{2'b11, 32'h53FFF3FF, 32'h1C000120, 2'b00, 5'd0, 2'b00, 5'd0, 3'b111, 32'h1C000110,
      5'd28, 2'b01, 12'h000, 8'h00, 5'b00000, 5'd31, 32'hFFFFFFFC, SRC_RF, SRC_RF},
    '{2'b10, 32'h50000400, 32'h1C000200, 2'b00, 5'd0, 2'b00, 5'd0, 3'b001, 32'h0, 5'd1,
      2'b11, 12'h000, 8'h00, 5'b00000, 5'd0, 32'h0, SRC_RF, SRC_RF},
    '{2'b01, 32'h50000400, 32'h1C000200, 2'b00, 5'd0, 2'b00, 5'd0, 3'b101, 32'h0, 5'd1,
      2'b10, 12'h000, 8'h00, 5'b00000, 5'd0, 32'h0, SRC_RF, SRC_RF}
};

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

    `include "tb_id_vectors.svh"

    localparam data_t RESET_PC    = DEFAULT_RESET_PC;
    localparam data_t EX_RES      = 32'h0E0E0E0E;
    localparam data_t MEM_RES     = 32'h3E3E3E3E;
    localparam data_t WB_RES      = 32'hB5B5B5B5;  // negative, so signed and unsigned differ.
    localparam data_t WB_LD       = 32'h7D7D7D7D;
    localparam int    WATCHDOG_NS = (NUM_VECS * 20 + 10 + 2) * 10;

    logic      clk, rst, in_valid, in_ready, out_ready, out_valid;
    data_t     inst, pc, ex_result, mem_result, wb_load_data, wb_result;
    logic      mem_valid, mem_gr_we, mem_res_from_mem;
    logic      wb_valid, wb_gr_we, wb_res_from_mem;
    reg_addr_t mem_dest, wb_dest, rf_raddr1, rf_raddr2, dest_out;
    data_t     rf_rdata1, rf_rdata2, br_target, imm_out, pc_out, rj_value_out, rkd_value_out;
    logic      br_taken, src1_is_pc_out, src2_is_imm_out, res_from_mem_out, gr_we_out;
    logic      mem_we_out;
    mem_op_t   load_op_out;
    alu_op_t   alu_op_out;

    data_t     rf_mem [32];
    int        data_errs, alu_errs, mem_errs, addr_errs, bit_errs;

    alu_op_t   snap_alu;
    mem_op_t   snap_mem;
    logic [4:0] snap_flags;
    reg_addr_t snap_dest;
    data_t     snap_imm, snap_pc, snap_rj, snap_rkd;

    id_stage #(.RESET_PC(RESET_PC)) uut (.*);

    assign rf_rdata1 = rf_mem[rf_raddr1];  // register file read is combinational.
    assign rf_rdata2 = rf_mem[rf_raddr2];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the stimulus table did not complete in the expected time.");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            data_errs++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_alu(input string name, input alu_op_t exp, input alu_op_t act);
        if (exp !== act) begin
            alu_errs++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mem(input string name, input mem_op_t exp, input mem_op_t act);
        if (exp !== act) begin
            mem_errs++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            addr_errs++;
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            bit_errs++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // value an operand must have, from the source the table names for it.
    function automatic data_t operand_value(input logic [2:0] src, input reg_addr_t addr);
        case (src)
            SRC_EX:   return EX_RES;
            SRC_MEM:  return MEM_RES;
            SRC_WB:   return WB_RES;
            SRC_WBLD: return WB_LD;
            default:  return rf_mem[addr];
        endcase
    endfunction

    task automatic apply_row(input vec_t v);
        {in_valid, out_ready} = v.hs;
        inst             = v.inst;
        pc               = v.pc;
        {mem_valid, mem_res_from_mem} = v.mem_fwd;
        mem_dest         = v.mem_dest;
        {wb_valid, wb_res_from_mem}   = v.wb_fwd;
        wb_dest          = v.wb_dest;
    endtask

    task automatic check_comb(input vec_t v);
        check_bit("in_ready", v.pre[2], in_ready);
        check_bit("br_taken", v.pre[1], br_taken);
        if (v.pre[0]) check_data("br_target", v.br_target, br_target);
        check_addr("rf_raddr1", v.inst[9:5], rf_raddr1);  // rj field.
        check_addr("rf_raddr2", v.raddr2, rf_raddr2);
        snap_alu   = alu_op_out;
        snap_mem   = load_op_out;
        snap_flags = {src1_is_pc_out, res_from_mem_out, gr_we_out, mem_we_out, src2_is_imm_out};
        snap_dest  = dest_out;
        snap_imm   = imm_out;
        snap_pc    = pc_out;
        snap_rj    = rj_value_out;
        snap_rkd   = rkd_value_out;
    endtask

    task automatic check_regs(input vec_t v);
        check_bit("out_valid", v.post[0], out_valid);
        if (v.post[1]) begin
            check_alu("alu_op_out (held)", snap_alu, alu_op_out);
            check_mem("load_op_out (held)", snap_mem, load_op_out);
            check_addr("dest_out (held)", snap_dest, dest_out);
            check_data("imm_out (held)", snap_imm, imm_out);
            check_data("pc_out (held)", snap_pc, pc_out);
            check_data("rj_value_out (held)", snap_rj, rj_value_out);
            check_data("rkd_value_out (held)", snap_rkd, rkd_value_out);
            check_bit("src1_is_pc_out (held)", snap_flags[4], src1_is_pc_out);
            check_bit("res_from_mem_out (held)", snap_flags[3], res_from_mem_out);
            check_bit("gr_we_out (held)", snap_flags[2], gr_we_out);
            check_bit("mem_we_out (held)", snap_flags[1], mem_we_out);
            check_bit("src2_is_imm_out (held)", snap_flags[0], src2_is_imm_out);
        end else begin
            check_alu("alu_op_out", v.alu, alu_op_out);
            check_mem("load_op_out", v.mem, load_op_out);
            check_bit("src1_is_pc_out", v.flags[4], src1_is_pc_out);
            check_bit("res_from_mem_out", v.flags[3], res_from_mem_out);
            check_bit("gr_we_out", v.flags[2], gr_we_out);
            check_bit("mem_we_out", v.flags[1], mem_we_out);
            check_bit("src2_is_imm_out", v.flags[0], src2_is_imm_out);
            check_addr("dest_out", v.dest, dest_out);
            check_data("imm_out", v.imm, imm_out);
            check_data("pc_out", v.pc, pc_out);
            check_data("rj_value_out", operand_value(v.rj_src, v.inst[9:5]), rj_value_out);
            check_data("rkd_value_out", operand_value(v.rkd_src, v.raddr2), rkd_value_out);
        end
    endtask

    initial begin
        int total;
        void'($urandom(95486));
        rf_mem[0] = '0;  // r0 always reads zero.
        for (int r = 1; r < 32; r++) rf_mem[r] = $urandom();
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b1;
        inst = '0;
        pc = '0;
        ex_result = EX_RES;
        mem_valid = 1'b0;
        mem_gr_we = 1'b1;
        mem_res_from_mem = 1'b0;
        mem_dest = '0;
        mem_result = MEM_RES;
        wb_valid = 1'b0;
        wb_gr_we = 1'b1;
        wb_res_from_mem = 1'b0;
        wb_dest = '0;
        wb_load_data = WB_LD;
        wb_result = WB_RES;
        repeat (10) @(posedge clk);
        #1;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b0, in_ready);
        check_bit("br_taken", 1'b0, br_taken);
        check_data("pc_out", RESET_PC, pc_out);
        check_alu("alu_op_out", '0, alu_op_out);
        rst = 1'b0;
        for (int i = 0; i < NUM_VECS; i++) begin
            apply_row(VECS[i]);
            #6;
            check_comb(VECS[i]);
            @(posedge clk);
            #1;
            check_regs(VECS[i]);
        end
        total = data_errs + alu_errs + mem_errs + addr_errs + bit_errs;
        $display("Errors: data %0d, alu %0d, mem %0d, addr %0d, bit %0d",
                 data_errs, alu_errs, mem_errs, addr_errs, bit_errs);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
